/* Bender.yml */
package:
  name: bch_outer_codec

sources:
  # design, package first
  - files:
      - rtl/bch_pkg.sv
      - rtl/bch_lfsr_core.sv
      - rtl/word_counter.sv
      - rtl/frame_fsm.sv
      - rtl/bch_encoder.sv
      - rtl/bch_checker.sv
      - rtl/bch_outer_codec.sv
  # verification
  - target: test
    files:
      - testbench/bch_outer_codec_assertions.sv
      - testbench/tb_bch_outer_codec.sv

/* rtl/bch_checker.sv */
// outer BCH parity checker: recompute remainder, compare parity and tail, flag per frame
`timescale 1ns/1ps

module bch_checker (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  bch_pkg::bch_stream_t in_beat,
  output logic                 done,
  output logic                 err
);

  import bch_pkg::*;

  frame_phase_t phase;
  cnt_t         idx;
  logic         last_data;
  logic         last_word;
  logic         clear;
  logic         shift_en;
  logic         chk_beat;
  logic         tail_beat;
  logic         mismatch;
  // any mismatch so far in this frame
  logic         err_acc;
  par_t         rem;
  word_t        exp_word;

  //--------------------------------------------------------------------------
  // same frame tracking chain as the encoder
  //--------------------------------------------------------------------------

  word_counter u_word_counter (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .beat      (in_beat),
    .idx       (idx),
    .last_data (last_data),
    .last_word (last_word)
  );

  frame_fsm u_frame_fsm (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .beat      (in_beat),
    .last_data (last_data),
    .last_word (last_word),
    .phase     (phase)
  );

  assign clear    = in_beat.val & in_beat.sop;
  assign shift_en = in_beat.val & (in_beat.sop | (phase == PH_DATA));

  // remainder is held through the parity and tail words
  bch_lfsr_core u_bch_lfsr_core (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .clear      (clear),
    .shift_en   (shift_en),
    .din        (in_beat.dat),
    .state      (rem),
    .state_next ()
  );

  //--------------------------------------------------------------------------
  // compare
  //--------------------------------------------------------------------------

  // idx still names the current word here
  always_comb begin
    if (phase == PH_TAIL) begin
      exp_word = tail_word(rem);
    end
    else if (idx == cnt_t'(cDATA_WORDS)) begin
      exp_word = rem[cDAT_W-1 : 0];
    end
    else begin
      exp_word = rem[2*cDAT_W-1 : cDAT_W];
    end
  end

  assign chk_beat  = in_beat.val & ~in_beat.sop & ((phase == PH_PARITY) | (phase == PH_TAIL));
  assign tail_beat = in_beat.val & ~in_beat.sop & (phase == PH_TAIL);
  // full word compare, pad bits of the tail included
  assign mismatch  = chk_beat & (in_beat.dat != exp_word);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      err_acc <= 1'b0;
      done    <= 1'b0;
      err     <= 1'b0;
    end
    else if (iclkena) begin
      done <= tail_beat;
      // result holds until the next frame ends
      if (tail_beat) begin
        err <= err_acc | mismatch;
      end
      if (in_beat.val) begin
        if (in_beat.sop) begin
          err_acc <= 1'b0;
        end
        else if (mismatch) begin
          err_acc <= 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/bch_encoder.sv */
// outer BCH encoder datapath: payload pass, parity and tail insertion, sop/eop
`timescale 1ns/1ps

module bch_encoder (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  bch_pkg::bch_stream_t in_beat,
  output bch_pkg::bch_stream_t out_beat,
  output logic                 eop
);

  import bch_pkg::*;

  frame_phase_t phase;
  logic         last_data;
  logic         last_word;
  logic         data_sel;
  logic         clear;
  logic         shift_en;
  logic         tail_beat;
  // low parity word already sent
  logic         hi_sel;
  par_t         par;
  word_t        code_word;
  logic         oval;
  logic         osop;
  word_t        odat;

  //--------------------------------------------------------------------------
  // frame tracking
  //--------------------------------------------------------------------------

  word_counter u_word_counter (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .beat      (in_beat),
    .idx       (),
    .last_data (last_data),
    .last_word (last_word)
  );

  frame_fsm u_frame_fsm (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .beat      (in_beat),
    .last_data (last_data),
    .last_word (last_word),
    .phase     (phase)
  );

  // payload words, sop beat is word 0 whatever the phase
  assign data_sel  = in_beat.sop | (phase == PH_DATA);
  assign clear     = in_beat.val & in_beat.sop;
  assign shift_en  = in_beat.val & data_sel;
  assign tail_beat = in_beat.val & ~in_beat.sop & (phase == PH_TAIL);

  // remainder holds after word 238, so state_next is the final parity
  bch_lfsr_core u_bch_lfsr_core (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .clear      (clear),
    .shift_en   (shift_en),
    .din        (in_beat.dat),
    .state      (),
    .state_next (par)
  );

  //--------------------------------------------------------------------------
  // output word select
  //--------------------------------------------------------------------------

  always_comb begin
    if (data_sel) begin
      code_word = in_beat.dat;
    end
    else begin
      case (phase)
        PH_PARITY: code_word = hi_sel ? par[2*cDAT_W-1 : cDAT_W] : par[cDAT_W-1 : 0];
        PH_TAIL:   code_word = tail_word(par);
        // words after the tail go out untouched
        default:   code_word = in_beat.dat;
      endcase
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval   <= 1'b0;
      osop   <= 1'b0;
      eop    <= 1'b0;
      hi_sel <= 1'b0;
    end
    else if (iclkena) begin
      oval <= in_beat.val;
      osop <= in_beat.val & in_beat.sop;
      eop  <= tail_beat;
      if (in_beat.val) begin
        hi_sel <= ~in_beat.sop & (phase == PH_PARITY) & ~hi_sel;
      end
    end
  end

  // payload register
  always_ff @(posedge iclk) begin
    if (iclkena && in_beat.val) begin
      odat <= code_word;
    end
  end

  assign out_beat = '{val: oval, sop: osop, dat: odat};

endmodule

/* rtl/bch_lfsr_core.sv */
// LFSR remainder register with a 16 bit per cycle division step
`timescale 1ns/1ps

module bch_lfsr_core (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           clear,
  input  logic           shift_en,
  input  bch_pkg::word_t din,
  output bch_pkg::par_t  state,
  output bch_pkg::par_t  state_next
);

  import bch_pkg::*;

  //--------------------------------------------------------------------------
  // the register shifts right, so the taps are the generator reversed
  // x^36 term is implicit and dropped
  //--------------------------------------------------------------------------

  function automatic par_t rev_taps();
    par_t r;
    for (int i = 0; i < cPAR_W; i++) begin
      r[i] = cGPOLY[cPAR_W-1-i];
    end
    return r;
  endfunction

  localparam par_t cTAPS = rev_taps();

  // divide one word into the remainder, bit 0 enters first
  function automatic par_t div_word(input par_t s, input word_t d);
    par_t r;
    logic fb;
    r = s;
    for (int b = 0; b < cDAT_W; b++) begin
      fb = d[b] ^ r[0];
      r  = (r >> 1) ^ (cTAPS & {cPAR_W{fb}});
    end
    return r;
  endfunction

  par_t base;

  // clear restarts from zero, otherwise continue from the held remainder
  always_comb begin
    base       = clear ? '0 : state;
    state_next = shift_en ? div_word(base, din) : base;
  end

  // without clear or shift_en, state_next equals state and the register holds
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= '0;
    end
    else if (iclkena) begin
      state <= state_next;
    end
  end

endmodule

/* rtl/bch_outer_codec.sv */
// outer codec top: BCH encoder on the tx stream, parity checker on the rx stream
`timescale 1ns/1ps

module bch_outer_codec (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  // transmit side
  input  bch_pkg::bch_stream_t tx_in,
  output bch_pkg::bch_stream_t tx_out,
  output logic                 tx_eop,
  // receive side
  input  bch_pkg::bch_stream_t rx_in,
  output logic                 chk_done,
  output logic                 chk_err
);

  //--------------------------------------------------------------------------
  // encoder, one enabled cycle latency, parity replaces words 239..241
  //--------------------------------------------------------------------------

  bch_encoder u_bch_encoder (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .in_beat  (tx_in),
    .out_beat (tx_out),
    .eop      (tx_eop)
  );

  //--------------------------------------------------------------------------
  // checker, done pulses after word 241, err holds until the next done
  //--------------------------------------------------------------------------

  bch_checker u_bch_checker (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .in_beat (rx_in),
    .done    (chk_done),
    .err     (chk_err)
  );

endmodule

/* rtl/bch_pkg.sv */
// outer BCH (3860,3824) code constants, word and parity types, stream struct, phase enum
package bch_pkg;

  //--------------------------------------------------------------------------
  // code dimensions
  //--------------------------------------------------------------------------

  // word width of both streams
  localparam int cDAT_W       = 16;
  // parity bits, also the LFSR width
  localparam int cPAR_W       = 36;
  // 3824 payload bits in 16 bit words
  localparam int cDATA_WORDS  = 239;
  // payload + 2 full parity words + tail word
  localparam int cFRAME_WORDS = 242;

  // generator polynomial, natural order, msb is x^36
  localparam logic [cPAR_W : 0] cGPOLY = 37'h104ACC7845;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [cDAT_W-1 : 0] word_t;
  typedef logic [cPAR_W-1 : 0] par_t;
  typedef logic [7 : 0]        cnt_t;

  // one beat of a word stream
  typedef struct packed {
    logic  val;
    logic  sop;
    word_t dat;
  } bch_stream_t;

  // position of the next word inside the frame
  typedef enum logic [1 : 0] {
    PH_IDLE,
    PH_DATA,
    PH_PARITY,
    PH_TAIL
  } frame_phase_t;

  // tail word: parity 35:34 in bits 9:8, parity 33:32 in bits 1:0, rest zero
  function automatic word_t tail_word(input par_t par);
    tail_word = {6'h0, par[cPAR_W-1 -: 2], 6'h0, par[cPAR_W-3 -: 2]};
  endfunction

endpackage

/* rtl/frame_fsm.sv */
// frame phase FSM: idle, payload, parity words, tail word
`timescale 1ns/1ps

module frame_fsm (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  iclkena,
  input  bch_pkg::bch_stream_t  beat,
  input  logic                  last_data,
  input  logic                  last_word,
  output bch_pkg::frame_phase_t phase
);

  import bch_pkg::*;

  frame_phase_t phase_next;
  // second parity word is next
  logic         par_hi;
  logic         par_hi_next;

  //--------------------------------------------------------------------------
  // next state, only accepted beats move the FSM
  //--------------------------------------------------------------------------

  always_comb begin
    phase_next  = phase;
    par_hi_next = par_hi;
    if (beat.val) begin
      if (beat.sop) begin
        // sop restarts the frame from any phase
        phase_next  = PH_DATA;
        par_hi_next = 1'b0;
      end
      else begin
        case (phase)
          PH_DATA: begin
            if (last_data) begin
              phase_next = PH_PARITY;
            end
          end
          PH_PARITY: begin
            // word 239 then word 240
            par_hi_next = ~par_hi;
            if (par_hi) begin
              phase_next = PH_TAIL;
            end
          end
          PH_TAIL: begin
            if (last_word) begin
              phase_next = PH_IDLE;
            end
          end
          // trailing words without sop are not part of any frame
          default: phase_next = PH_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      phase  <= PH_IDLE;
      par_hi <= 1'b0;
    end
    else if (iclkena) begin
      phase  <= phase_next;
      par_hi <= par_hi_next;
    end
  end

endmodule

/* rtl/word_counter.sv */
// word index within a frame with look-ahead last data / last word flags
`timescale 1ns/1ps

module word_counter (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  bch_pkg::bch_stream_t beat,
  output bch_pkg::cnt_t        idx,
  output logic                 last_data,
  output logic                 last_word
);

  import bch_pkg::*;

  //--------------------------------------------------------------------------
  // idx holds the number of the next word to arrive
  // flags are registered one beat early so users act on the beat itself
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx       <= '0;
      last_data <= 1'b0;
      last_word <= 1'b0;
    end
    else if (iclkena && beat.val) begin
      if (beat.sop) begin
        // sop beat is word 0, next is word 1
        idx       <= cnt_t'(1);
        last_data <= 1'b0;
        last_word <= 1'b0;
      end
      else begin
        // saturate past the frame end so trailing words never wrap
        if (idx != cnt_t'(cFRAME_WORDS)) begin
          idx <= idx + 1'b1;
        end
        // next beat is word 238
        last_data <= (idx == cnt_t'(cDATA_WORDS - 2));
        // next beat is word 241
        last_word <= (idx == cnt_t'(cFRAME_WORDS - 2));
      end
    end
  end

endmodule

/* src.f */
rtl/bch_pkg.sv
rtl/bch_lfsr_core.sv
rtl/word_counter.sv
rtl/frame_fsm.sv
rtl/bch_encoder.sv
rtl/bch_checker.sv
rtl/bch_outer_codec.sv
testbench/bch_outer_codec_assertions.sv
testbench/tb_bch_outer_codec.sv

/* testbench/bch_outer_codec_assertions.sv */
// concurrent checks on the codec top level stream and check outputs, bound to the top
`timescale 1ns/1ps

module bch_outer_codec_assertions (
  input logic                 iclk,
  input logic                 ireset,
  input logic                 iclkena,
  input bch_pkg::bch_stream_t tx_out,
  input logic                 tx_eop,
  input logic                 chk_done,
  input logic                 chk_err
);

  // frame markers only come with a valid word
  sop_has_val: assert property (@(posedge iclk) disable iff (ireset)
    tx_out.sop |-> tx_out.val)
    else $error("tx_out.sop high without tx_out.val");

  eop_has_val: assert property (@(posedge iclk) disable iff (ireset)
    tx_eop |-> tx_out.val)
    else $error("tx_eop high without tx_out.val");

  // done drops after one enabled edge
  done_pulse: assert property (@(posedge iclk) disable iff (ireset)
    (chk_done && iclkena) |=> !chk_done)
    else $error("chk_done longer than one enabled cycle");

  // err moves only together with a done pulse
  err_stable: assert property (@(posedge iclk) disable iff (ireset)
    (chk_err != $past(chk_err)) |-> chk_done)
    else $error("chk_err changed between chk_done pulses");

endmodule

bind bch_outer_codec bch_outer_codec_assertions u_bch_outer_codec_assertions (.*);

/* testbench/tb_bch_outer_codec.sv */
// outer BCH codec testbench with reference parity, stimulus, monitors and directed tests
`timescale 1ns/1ps

module tb_bch_outer_codec;

  import bch_pkg::*;

  // nine full frames and two partial ones, about doubled for the stalls of the gap tests
  localparam int cMAX_CYCLES = 20 * cFRAME_WORDS;

  logic        iclk;
  logic        ireset;
  logic        iclkena;
  bch_stream_t tx_in;
  bch_stream_t tx_out;
  logic        tx_eop;
  bch_stream_t rx_in;
  logic        chk_done;
  logic        chk_err;

  integer seed;
  int     err_cnt;
  int     cyc  = 0;
  // last clock edge was enabled
  logic   en_q = 1'b0;
  // collected encoder output, one entry per accepted output word
  word_t  out_q[$];
  logic   sop_q[$];
  logic   eop_q[$];
  int     out_cnt;
  int     eop_cnt;
  int     in_sop_cyc;
  int     out_sop_cyc;
  int     done_cnt;
  logic   done_err;
  word_t  tx_buf   [cFRAME_WORDS];
  word_t  rx_buf   [cFRAME_WORDS];
  word_t  code_buf [cFRAME_WORDS];
  par_t   par;

  bch_outer_codec u_bch_outer_codec (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .tx_in    (tx_in),
    .tx_out   (tx_out),
    .tx_eop   (tx_eop),
    .rx_in    (rx_in),
    .chk_done (chk_done),
    .chk_err  (chk_err)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  //--------------------------------------------------------------------------
  // monitors, sampled on the falling edge where outputs are stable
  //--------------------------------------------------------------------------

  always @(posedge iclk) begin
    cyc  <= cyc + 1;
    en_q <= iclkena;
  end

  // outputs hold while the enable is low, so only count words after enabled edges
  always @(negedge iclk) begin
    if (!ireset && en_q) begin
      if (tx_out.val) begin
        out_q.push_back(tx_out.dat);
        sop_q.push_back(tx_out.sop);
        eop_q.push_back(tx_eop);
        out_cnt++;
        if (tx_eop) begin
          eop_cnt++;
        end
        if (tx_out.sop) begin
          out_sop_cyc = cyc;
        end
      end
      if (chk_done) begin
        done_cnt++;
        done_err = chk_err;
      end
    end
  end

  always @(posedge iclk) begin
    if (cyc >= cMAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", cMAX_CYCLES);
      $display("errors: %0d", err_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  // long division of m(x)*x^36 by g(x), first payload bit is the top coefficient
  function automatic par_t ref_parity();
    logic [cDATA_WORDS*cDAT_W+cPAR_W-1 : 0] poly;
    par_t                                   p;
    int                                     n;
    n    = cDATA_WORDS * cDAT_W;
    poly = '0;
    for (int j = 0; j < n; j++) begin
      poly[n+cPAR_W-1-j] = tx_buf[j/cDAT_W][j%cDAT_W];
    end
    for (int d = n + cPAR_W - 1; d >= cPAR_W; d--) begin
      if (poly[d]) begin
        poly[d-cPAR_W +: cPAR_W+1] ^= cGPOLY;
      end
    end
    // parity goes out highest remainder degree first, so bit 0 is x^35
    for (int i = 0; i < cPAR_W; i++) begin
      p[i] = poly[cPAR_W-1-i];
    end
    return p;
  endfunction

  // code word w of the frame in tx_buf
  function automatic word_t expected_word(input int w);
    word_t t;
    t = '0;
    if (w < cDATA_WORDS) begin
      t = tx_buf[w];
    end
    else if (w == cDATA_WORDS) begin
      t = par[15:0];
    end
    else if (w == cDATA_WORDS + 1) begin
      t = par[31:16];
    end
    else begin
      t[9:8] = par[35:34];
      t[1:0] = par[33:32];
    end
    return t;
  endfunction

  //--------------------------------------------------------------------------
  // stimulus helpers
  //--------------------------------------------------------------------------

  task automatic report_mismatch(input string test, input string what,
                                 input logic [35:0] exp, input logic [35:0] act);
    err_cnt++;
    $display("ERROR %s %s: expected %h actual %h", test, what, exp, act);
  endtask

  task automatic put_beat(input bit to_rx, input bch_stream_t b);
    if (to_rx) begin
      rx_in = b;
    end
    else begin
      tx_in = b;
    end
  endtask

  // random payload, placeholders included, and its reference parity
  task automatic fill_payload();
    for (int w = 0; w < cFRAME_WORDS; w++) begin
      tx_buf[w] = word_t'($random(seed));
    end
    par = ref_parity();
  endtask

  task automatic start_collect();
    out_q.delete();
    sop_q.delete();
    eop_q.delete();
    out_cnt = 0;
    eop_cnt = 0;
  endtask

  // sop on word 0, optional random enable stalls and idle cycles
  task automatic drive_frame(input bit to_rx, input int nwords, input bit gappy);
    bch_stream_t b;
    int          r;
    for (int w = 0; w < nwords; w++) begin
      b.val = 1'b1;
      b.sop = (w == 0);
      b.dat = to_rx ? rx_buf[w] : tx_buf[w];
      @(negedge iclk);
      if (gappy) begin
        r = $unsigned($random(seed)) % 8;
        if (r == 0) begin
          // enable off for 1 to 4 cycles while the beat waits on the bus
          iclkena = 1'b0;
          put_beat(to_rx, b);
          repeat (1 + $unsigned($random(seed)) % 4) @(negedge iclk);
        end
        else if (r == 1) begin
          // idle cycle with junk data
          put_beat(to_rx, '{val: 1'b0, sop: 1'b0, dat: word_t'($random(seed))});
          @(negedge iclk);
        end
      end
      iclkena = 1'b1;
      put_beat(to_rx, b);
      if (b.sop && !to_rx) begin
        in_sop_cyc = cyc + 1;
      end
    end
    @(negedge iclk);
    put_beat(to_rx, '0);
  endtask

  // compare one collected frame from entry first and keep it for the checker
  task automatic compare_encoded(input string test, input int first);
    for (int w = 0; w < cFRAME_WORDS; w++) begin
      if (out_q[first+w] !== expected_word(w)) begin
        report_mismatch(test, $sformatf("word %0d", w), expected_word(w), out_q[first+w]);
      end
      if (sop_q[first+w] !== (w == 0)) begin
        report_mismatch(test, $sformatf("sop at word %0d", w), (w == 0), sop_q[first+w]);
      end
      if (eop_q[first+w] !== (w == cFRAME_WORDS - 1)) begin
        report_mismatch(test, $sformatf("eop at word %0d", w), (w == cFRAME_WORDS - 1),
                        eop_q[first+w]);
      end
      code_buf[w] = out_q[first+w];
    end
  endtask

  // send rx_buf and wait for its done pulse
  task automatic check_frame(input string test, input bit gappy, input logic exp_err);
    int n0;
    n0 = done_cnt;
    drive_frame(1'b1, cFRAME_WORDS, gappy);
    wait (done_cnt > n0);
    repeat (4) @(negedge iclk);
    if (done_cnt != n0 + 1) begin
      report_mismatch(test, "done count", n0 + 1, done_cnt);
    end
    if (done_err !== exp_err) begin
      report_mismatch(test, "chk_err", exp_err, done_err);
    end
  endtask

  //--------------------------------------------------------------------------
  // tests
  //--------------------------------------------------------------------------

  task automatic idle_after_reset();
    repeat (4) begin
      @(negedge iclk);
      if (tx_out.val !== 1'b0) begin
        report_mismatch("reset_idle", "tx_out.val", 0, tx_out.val);
      end
      if (tx_eop !== 1'b0) begin
        report_mismatch("reset_idle", "tx_eop", 0, tx_eop);
      end
      if (chk_done !== 1'b0) begin
        report_mismatch("reset_idle", "chk_done", 0, chk_done);
      end
      if (chk_err !== 1'b0) begin
        report_mismatch("reset_idle", "chk_err", 0, chk_err);
      end
    end
  endtask

  task automatic encode_frame(input string test, input bit gappy);
    fill_payload();
    start_collect();
    drive_frame(1'b0, cFRAME_WORDS, gappy);
    wait (out_cnt >= cFRAME_WORDS);
    compare_encoded(test, 0);
    // output sop right after the edge that took the input sop
    if (out_sop_cyc != in_sop_cyc) begin
      report_mismatch(test, "sop cycle", in_sop_cyc, out_sop_cyc);
    end
  endtask

  task automatic detect_errors();
    int b;
    rx_buf = code_buf;
    b = $unsigned($random(seed)) % (cDATA_WORDS * cDAT_W);
    rx_buf[b/cDAT_W][b%cDAT_W] ^= 1'b1;
    check_frame("err_payload", 1'b0, 1'b1);
    rx_buf = code_buf;
    b = $unsigned($random(seed)) % (2 * cDAT_W);
    rx_buf[cDATA_WORDS+b/cDAT_W][b%cDAT_W] ^= 1'b1;
    check_frame("err_parity", 1'b0, 1'b1);
    // tail pad bits are 7:2 and 15:10
    rx_buf = code_buf;
    b = $unsigned($random(seed)) % 12;
    b = (b < 6) ? b + 2 : b + 4;
    rx_buf[cFRAME_WORDS-1][b] ^= 1'b1;
    check_frame("err_tail_pad", 1'b0, 1'b1);
  endtask

  task automatic restart_mid_frame();
    int n0;
    // abandoned 100 word frame, then a full one
    fill_payload();
    start_collect();
    drive_frame(1'b0, 100, 1'b0);
    fill_payload();
    drive_frame(1'b0, cFRAME_WORDS, 1'b0);
    wait (out_cnt >= 100 + cFRAME_WORDS);
    repeat (4) @(negedge iclk);
    compare_encoded("restart_tx", 100);
    if (eop_cnt != 1) begin
      report_mismatch("restart_tx", "eop count", 1, eop_cnt);
    end
    // junk partial frame on rx, then the clean code word
    for (int w = 0; w < cFRAME_WORDS; w++) begin
      rx_buf[w] = word_t'($random(seed));
    end
    n0 = done_cnt;
    drive_frame(1'b1, 120, 1'b0);
    repeat (4) @(negedge iclk);
    if (done_cnt != n0) begin
      report_mismatch("restart_rx", "done after partial frame", n0, done_cnt);
    end
    rx_buf = code_buf;
    check_frame("restart_rx", 1'b0, 1'b0);
  endtask

  initial begin
    seed     = 98192;
    err_cnt  = 0;
    out_cnt  = 0;
    eop_cnt  = 0;
    done_cnt = 0;
    done_err = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    tx_in    = '0;
    rx_in    = '0;
    // five rising edges in reset, release on the following falling edge
    repeat (5) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    idle_after_reset();
    encode_frame("encode", 1'b0);
    rx_buf = code_buf;
    check_frame("loopback", 1'b0, 1'b0);
    detect_errors();
    encode_frame("gaps_encode", 1'b1);
    rx_buf = code_buf;
    check_frame("gaps_loopback", 1'b1, 1'b0);
    restart_mid_frame();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end
    else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
